//--- hw/geom_pkg.sv
package geom_pkg;

	////////////////////
	// grid types

	typedef logic [7:0] coord_t;   // one axis position

	// x sits in the low byte, matching the bus word layout
	typedef struct packed {
		coord_t y;
		coord_t x;
	} node_t;

	typedef logic [15:0] cost_t;

	typedef logic [5:0] list_idx_t;
	typedef logic [6:0] list_cnt_t;   // 0 up to a full list

	////////////////////
	// list size and heuristic weights

	localparam int OPEN_DEPTH = 64;

	localparam cost_t COST_STRAIGHT = 16'd10;   // one axis step
	localparam cost_t COST_DIAG = 16'd14;   // one diagonal step, ~10*sqrt(2)

endpackage

//--- hw/bus_pkg.sv
package bus_pkg;

	////////////////////
	// wishbone classic

	localparam int WB_ADR_W = 8;
	localparam int WB_DAT_W = 16;

	typedef logic [WB_ADR_W-1:0] wb_adr_t;
	typedef logic [WB_DAT_W-1:0] wb_dat_t;

	// master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_adr_t adr;
		wb_dat_t dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		wb_dat_t dat;
	} wb_rsp_t;

	////////////////////
	// word address map

	localparam wb_adr_t ADR_CTRL = 8'h00;   // bit 0 starts a sort
	localparam wb_adr_t ADR_STATUS = 8'h01;   // bit 0 busy, bit 1 done
	localparam wb_adr_t ADR_GOAL = 8'h02;
	localparam wb_adr_t ADR_COUNT = 8'h03;
	localparam wb_adr_t ADR_LIST_BASE = 8'h40;   // 64 word window up to 0x7f

endpackage

//--- hw/octile_cost.sv
`timescale 1ns/1ps

module octile_cost import geom_pkg::*;
(
	input node_t node,
	input node_t goal,
	output cost_t cost
);

	coord_t dx;
	coord_t dy;
	coord_t d_min;
	coord_t d_max;

	always_comb
	begin
		dx = (node.x > goal.x) ? node.x - goal.x : goal.x - node.x;
		dy = (node.y > goal.y) ? node.y - goal.y : goal.y - node.y;
		if (dx < dy)
		begin
			d_min = dx;
			d_max = dy;
		end
		else
		begin
			d_min = dy;
			d_max = dx;
		end
	end

	// diagonal run first, straight remainder after
	assign cost = COST_DIAG * cost_t'(d_min) + COST_STRAIGHT * cost_t'(d_max - d_min);

endmodule

//--- hw/open_list_ram.sv
`timescale 1ns/1ps

module open_list_ram import geom_pkg::*;
(
	input logic Clk,
	input list_idx_t bus_addr,
	input logic bus_we,
	input node_t bus_wdata,
	output node_t bus_rdata,
	input list_idx_t pair_idx,
	input logic swap,
	output node_t pair_lo,
	output node_t pair_hi
);

	node_t mem [OPEN_DEPTH];
	list_idx_t hi_idx;

	assign hi_idx = pair_idx + 6'd1;   // wraps at 63, sorter stops one short

	// compare port, both entries straight from the array
	assign pair_lo = mem[pair_idx];
	assign pair_hi = mem[hi_idx];

	always_ff @(posedge Clk)
	begin
		// bus writes only land while the sorter is idle
		if (bus_we)
			mem[bus_addr] <= bus_wdata;
		else if (swap)
		begin
			mem[pair_idx] <= pair_hi;
			mem[hi_idx] <= pair_lo;
		end
		bus_rdata <= mem[bus_addr];
	end

endmodule

//--- hw/bubble_sorter.sv
`timescale 1ns/1ps

module bubble_sorter import geom_pkg::*;
(
	input logic Clk,
	input logic Reset,
	input logic start,
	input node_t goal,
	input list_cnt_t count,
	input node_t pair_lo,
	input node_t pair_hi,
	output list_idx_t pair_idx,
	output logic swap,
	output logic busy,
	output logic done
);

	typedef enum logic [1:0] {
		st_idle,
		st_compare,
		st_finish
	} state_t;

	state_t state;
	node_t goal_q;
	list_cnt_t count_q;
	list_idx_t last_idx;
	logic pass_swapped;   // anything moved in this pass
	cost_t cost_lo;
	cost_t cost_hi;

	octile_cost cost_lo_i
	(
		.node(pair_lo),
		.goal(goal_q),
		.cost(cost_lo)
	);

	octile_cost cost_hi_i
	(
		.node(pair_hi),
		.goal(goal_q),
		.cost(cost_hi)
	);

	assign last_idx = list_idx_t'(count_q - 7'd2);

	// strict test keeps equal costs in order
	assign swap = (state == st_compare) && (cost_hi > cost_lo);
	assign busy = (state != st_idle);

	// operands of the running sort
	always_ff @(posedge Clk)
	begin
		if (start && !busy)
		begin
			goal_q <= goal;
			count_q <= count;
		end
	end

	////////////////////
	// pass control

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= st_idle;
			pair_idx <= '0;
			pass_swapped <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (start)
					begin
						pair_idx <= '0;
						pass_swapped <= 1'b0;
						done <= 1'b0;
						state <= (count < 7'd2) ? st_finish : st_compare;   // nothing to order
					end
				end
				st_compare:
				begin
					if (pair_idx == last_idx)
					begin
						pair_idx <= '0;
						pass_swapped <= 1'b0;
						if (!(pass_swapped || swap))
							state <= st_finish;   // clean pass
					end
					else
					begin
						pair_idx <= pair_idx + 6'd1;
						pass_swapped <= pass_swapped || swap;
					end
				end
				st_finish:
				begin
					done <= 1'b1;
					state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

//--- hw/wb_sort_regs.sv
`timescale 1ns/1ps

module wb_sort_regs import geom_pkg::*, bus_pkg::*;
(
	input logic Clk,
	input logic Reset,
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output list_idx_t bus_addr,
	output logic bus_we,
	output node_t bus_wdata,
	input node_t bus_rdata,
	output logic start,
	output node_t goal,
	output list_cnt_t count,
	input logic busy,
	input logic done
);

	logic req_seen;   // stb already answered
	logic req_new;
	logic wr_ok;
	logic list_sel;
	logic ack_q;
	node_t goal_q;
	list_cnt_t count_q;
	list_cnt_t count_wr;
	wb_dat_t rd_mux;

	assign req_new = wb_req.cyc && wb_req.stb && !req_seen;
	assign wr_ok = req_new && wb_req.we && !busy;   // config frozen during a sort
	assign list_sel = (wb_req.adr[WB_ADR_W-1:6] == ADR_LIST_BASE[WB_ADR_W-1:6]);

	// larger counts clamp to a full list
	assign count_wr = (wb_req.dat > OPEN_DEPTH) ? list_cnt_t'(OPEN_DEPTH)
		: list_cnt_t'(wb_req.dat);

	////////////////////
	// list window

	assign bus_addr = list_idx_t'(wb_req.adr);
	assign bus_we = wr_ok && list_sel;
	assign bus_wdata = node_t'(wb_req.dat);

	assign goal = goal_q;
	assign count = count_q;

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			req_seen <= 1'b0;
			ack_q <= 1'b0;
			start <= 1'b0;
			goal_q <= '0;
			count_q <= '0;
		end
		else
		begin
			req_seen <= wb_req.cyc && wb_req.stb;
			ack_q <= req_new;
			start <= wr_ok && (wb_req.adr == ADR_CTRL) && wb_req.dat[0];
			if (wr_ok && (wb_req.adr == ADR_GOAL))
				goal_q <= node_t'(wb_req.dat);
			if (wr_ok && (wb_req.adr == ADR_COUNT))
				count_q <= count_wr;
		end
	end

	// address is held until ack, so the mux is read in the ack cycle
	always_comb
	begin
		if (list_sel)
			rd_mux = wb_dat_t'(bus_rdata);
		else
		begin
			case (wb_req.adr)
				ADR_STATUS: rd_mux = wb_dat_t'({done, busy});
				ADR_GOAL: rd_mux = wb_dat_t'(goal_q);
				ADR_COUNT: rd_mux = wb_dat_t'(count_q);
				default: rd_mux = '0;
			endcase
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rd_mux;

endmodule

//--- hw/astar_sort_top.sv
`timescale 1ns/1ps

module astar_sort_top import geom_pkg::*, bus_pkg::*;
(
	input logic Clk,
	input logic Reset,
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	// register block to list storage
	list_idx_t bus_addr;
	logic bus_we;
	node_t bus_wdata;
	node_t bus_rdata;

	// register block to sorter
	logic start;
	node_t goal;
	list_cnt_t count;
	logic busy;
	logic done;

	// sorter to list storage
	list_idx_t pair_idx;
	logic swap;
	node_t pair_lo;
	node_t pair_hi;

	wb_sort_regs wb_sort_regs_i
	(
		.Clk(Clk),
		.Reset(Reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.bus_addr(bus_addr),
		.bus_we(bus_we),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata),
		.start(start),
		.goal(goal),
		.count(count),
		.busy(busy),
		.done(done)
	);

	open_list_ram open_list_ram_i
	(
		.Clk(Clk),
		.bus_addr(bus_addr),
		.bus_we(bus_we),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata),
		.pair_idx(pair_idx),
		.swap(swap),
		.pair_lo(pair_lo),
		.pair_hi(pair_hi)
	);

	bubble_sorter bubble_sorter_i
	(
		.Clk(Clk),
		.Reset(Reset),
		.start(start),
		.goal(goal),
		.count(count),
		.pair_lo(pair_lo),
		.pair_hi(pair_hi),
		.pair_idx(pair_idx),
		.swap(swap),
		.busy(busy),
		.done(done)
	);

endmodule

//--- sim/astar_sort_tb.sv
`timescale 1ns/1ps

module astar_sort_tb import geom_pkg::*, bus_pkg::*;
();

	localparam int NUM_SORTS = 6;
	localparam int NUM_ACCESSES = 1000;
	// a sort needs at most OPEN_DEPTH passes of OPEN_DEPTH compares, 20 cycles per bus access
	localparam int TIMEOUT_CYCLES = 2 * (NUM_SORTS * OPEN_DEPTH * OPEN_DEPTH
		+ 20 * NUM_ACCESSES);

	logic Clk;
	logic Reset;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	logic [31:0] lfsr;
	int cycle_count;
	node_t shadow [OPEN_DEPTH];   // list as the host last left it
	node_t expected [OPEN_DEPTH];

	astar_sort_top astar_sort_top_i
	(
		.Clk(Clk),
		.Reset(Reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp)
	);

	always #50 Clk = ~Clk;

	always @(posedge Clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	////////////////////
	// stimulus and reference

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			val = {val[14:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic node_t random_node();
		node_t n;
		n.x = coord_t'(random_bits(8));
		n.y = coord_t'(random_bits(8));
		return n;
	endfunction

	function automatic int octile_ref(input node_t n, input node_t g);
		int dx;
		int dy;
		dx = int'(n.x) - int'(g.x);
		dy = int'(n.y) - int'(g.y);
		if (dx < 0)
			dx = -dx;
		if (dy < 0)
			dy = -dy;
		if (dx < dy)
			return int'(COST_DIAG) * dx + int'(COST_STRAIGHT) * (dy - dx);
		return int'(COST_DIAG) * dy + int'(COST_STRAIGHT) * (dx - dy);
	endfunction

	// stable insertion sort, larger cost first
	task automatic build_expected(input node_t g, input int cnt);
		node_t key;
		int j;
		for (int i = 0; i < OPEN_DEPTH; i++)
			expected[i] = shadow[i];
		for (int i = 1; i < cnt; i++)
		begin
			key = expected[i];
			j = i - 1;
			while (j >= 0)
			begin
				if (octile_ref(expected[j], g) >= octile_ref(key, g))
					break;   // equal cost stays ahead
				expected[j + 1] = expected[j];
				j--;
			end
			expected[j + 1] = key;
		end
	endtask

	////////////////////
	// bus driver and checks

	task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
		@(negedge Clk);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = 1'b1;
		wb_req.adr = adr;
		wb_req.dat = dat;
		@(negedge Clk);
		while (!wb_rsp.ack)
			@(negedge Clk);
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we = 1'b0;
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
		@(negedge Clk);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = 1'b0;
		wb_req.adr = adr;
		@(negedge Clk);
		while (!wb_rsp.ack)
			@(negedge Clk);
		dat = wb_rsp.dat;   // valid in the ack cycle
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] exp_val,
		input string what);
		if (actual !== exp_val)
		begin
			$display("FAILED at %0t ns: %s read %h, expected %h", $time, what, actual, exp_val);
			$display("TESTBENCH FAILED");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic load_list();
		for (int i = 0; i < OPEN_DEPTH; i++)
			wb_write(ADR_LIST_BASE + wb_adr_t'(i), wb_dat_t'(shadow[i]));
	endtask

	task automatic check_list(input string what);
		wb_dat_t dat;
		for (int i = 0; i < OPEN_DEPTH; i++)
		begin
			wb_read(ADR_LIST_BASE + wb_adr_t'(i), dat);
			check_equal(32'(dat), 32'(expected[i]), $sformatf("%s entry %0d", what, i));
		end
	endtask

	task automatic start_sort();
		wb_write(ADR_CTRL, 16'h0001);
	endtask

	task automatic wait_done();
		wb_dat_t status;
		status = 16'h0001;
		while (status[0])
			wb_read(ADR_STATUS, status);
		check_equal(32'(status), 32'h2, "status after sort");   // idle and done
	endtask

	task automatic sort_and_check(input node_t g, input int cnt, input string what);
		wb_write(ADR_GOAL, wb_dat_t'(g));
		wb_write(ADR_COUNT, wb_dat_t'(cnt));
		build_expected(g, cnt);
		start_sort();
		wait_done();
		check_list(what);
		shadow = expected;
	endtask

	////////////////////
	// tests

	task automatic test_reset_values();
		wb_dat_t dat;
		wb_read(ADR_STATUS, dat);
		check_equal(32'(dat), 32'h0, "status after reset");
		wb_read(ADR_GOAL, dat);
		check_equal(32'(dat), 32'h0, "goal after reset");
		wb_read(ADR_COUNT, dat);
		check_equal(32'(dat), 32'h0, "count after reset");
	endtask

	task automatic test_register_readback();
		node_t g;
		wb_dat_t dat;
		g = random_node();
		wb_write(ADR_GOAL, wb_dat_t'(g));
		wb_write(ADR_COUNT, 16'd37);
		wb_read(ADR_GOAL, dat);
		check_equal(32'(dat), 32'(g), "goal readback");
		wb_read(ADR_COUNT, dat);
		check_equal(32'(dat), 32'd37, "count readback");
		for (int i = 0; i < OPEN_DEPTH; i++)
			shadow[i] = random_node();
		load_list();
		expected = shadow;
		check_list("list readback");
	endtask

	task automatic test_random_sort();
		for (int i = 0; i < OPEN_DEPTH; i++)
			shadow[i] = random_node();
		load_list();
		sort_and_check(random_node(), OPEN_DEPTH, "random sort");
	endtask

	task automatic test_short_counts();
		sort_and_check(random_node(), 0, "count 0");
		sort_and_check(random_node(), 1, "count 1");
	endtask

	// small offsets around the goal give many equal costs
	task automatic test_ties_and_tail();
		node_t g;
		int d;
		int e;
		g.x = 8'd128;
		g.y = 8'd128;
		for (int i = 0; i < 40; i++)
		begin
			d = int'(random_bits(2));
			e = int'(random_bits(2));
			shadow[i].x = random_bits(1) ? coord_t'(128 + d) : coord_t'(128 - d);
			shadow[i].y = random_bits(1) ? coord_t'(128 + e) : coord_t'(128 - e);
		end
		for (int i = 40; i < OPEN_DEPTH; i++)
			shadow[i] = random_node();   // beyond count, must stay put
		load_list();
		sort_and_check(g, 40, "ties and tail");
	endtask

	task automatic test_busy_writes();
		node_t g;
		wb_dat_t status;
		wb_dat_t dat;
		for (int i = 0; i < OPEN_DEPTH; i++)
			shadow[i] = random_node();
		load_list();
		g = random_node();
		wb_write(ADR_GOAL, wb_dat_t'(g));
		wb_write(ADR_COUNT, wb_dat_t'(OPEN_DEPTH));
		build_expected(g, OPEN_DEPTH);
		start_sort();
		wb_read(ADR_STATUS, status);
		check_equal(32'(status[0]), 32'd1, "busy after start");
		wb_write(ADR_LIST_BASE, wb_dat_t'(~shadow[0]));
		wb_write(ADR_GOAL, wb_dat_t'(~g));
		start_sort();
		wait_done();
		check_list("writes while busy");
		wb_read(ADR_GOAL, dat);
		check_equal(32'(dat), 32'(g), "goal after busy write");
		shadow = expected;
	endtask

	task automatic test_resort_new_goal();
		node_t g;
		wb_dat_t status;
		g = random_node();
		wb_write(ADR_GOAL, wb_dat_t'(g));
		build_expected(g, OPEN_DEPTH);   // count still full
		start_sort();
		wb_read(ADR_STATUS, status);
		check_equal(32'(status[1]), 32'd0, "done after second start");
		wait_done();
		check_list("second sort");
		shadow = expected;
	endtask

	initial
	begin
		Clk = 1'b0;
		Reset = 1'b1;
		wb_req = '0;
		lfsr = 32'he428;
		cycle_count = 0;
		repeat (2) @(posedge Clk);
		@(negedge Clk);
		Reset = 1'b0;

		test_reset_values();
		test_register_readback();
		test_random_sort();
		test_short_counts();
		test_ties_and_tail();
		test_busy_writes();
		test_resort_new_goal();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- src.f
hw/geom_pkg.sv
hw/bus_pkg.sv
hw/octile_cost.sv
hw/open_list_ram.sv
hw/bubble_sorter.sv
hw/wb_sort_regs.sv
hw/astar_sort_top.sv
sim/astar_sort_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the open-list sorter testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=astar_sort_tb
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module "$TOP" -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
